// File: design/vic_bus_pkg.sv
package vic_bus_pkg;

    // cpu side of the chip, 6-bit register offsets, byte-wide data
    typedef logic [5:0] reg_addr_t;
    typedef logic [7:0] bus_data_t;
    typedef logic [3:0] color_t;   // palette index

    // register map
    localparam reg_addr_t reg_ctrl     = 6'h11; // bit 7 is raster / compare bit 8
    localparam reg_addr_t reg_raster   = 6'h12; // raster low byte, compare low byte
    localparam reg_addr_t reg_irq_flag = 6'h19; // write 1 to clear
    localparam reg_addr_t reg_irq_en   = 6'h1a;
    localparam reg_addr_t reg_border   = 6'h20;
    localparam reg_addr_t reg_bg       = 6'h21;

    // bit positions inside the registers
    localparam int ctrl_rst8_bit   = 7; // raster bit 8 in reg_ctrl
    localparam int irq_raster_bit  = 0; // raster flag in reg_irq_flag
    localparam int irq_en_rst_bit  = 0; // raster enable in reg_irq_en
    localparam int color_msb       = 3; // colors use the low nibble

    // undriven bits float high on the real part, so reads fill with ones
    localparam bus_data_t read_fill = 8'hff;

endpackage

// File: design/vic_video_pkg.sv
package vic_video_pkg;

    typedef logic [8:0] raster_t;    // line number
    typedef logic [8:0] hcount_t;    // tick within a line
    typedef logic [5:0] luma_level_t;
    typedef logic [5:0] chroma_t;
    typedef logic [3:0] phase_t;     // carrier phase, 16 steps per cycle

    // ntsc frame in ticks of the 16x color clock
    localparam hcount_t h_total      = 9'd260;
    localparam raster_t v_total      = 9'd263;
    localparam hcount_t hsync_ticks  = 9'd20;  // hsync low for ticks 0..19
    localparam raster_t vsync_lines  = 9'd3;   // vsync low for lines 0..2

    // visible window, inclusive on both ends
    localparam hcount_t disp_h_start = 9'd96;
    localparam hcount_t disp_h_end   = 9'd255;
    localparam raster_t disp_v_start = 9'd51;
    localparam raster_t disp_v_end   = 9'd250;

    localparam luma_level_t blank_level = 6'd0;  // sync tip
    localparam chroma_t     chroma_mid  = 6'd32; // zero chroma

    // luma per palette entry, black sits above the sync tip
    localparam luma_level_t luma_table [0:15] = '{
        6'd12, 6'd63, 6'd25, 6'd47, 6'd30, 6'd40, 6'd20, 6'd55,
        6'd30, 6'd20, 6'd40, 6'd25, 6'd35, 6'd55, 6'd35, 6'd47
    };

    // hue as a carrier phase offset
    localparam phase_t chroma_phase [0:15] = '{
        4'd0, 4'd0, 4'd5, 4'd13, 4'd2, 4'd10, 4'd0, 4'd8,
        4'd6, 4'd7, 4'd5, 4'd0, 4'd0, 4'd10, 4'd0, 4'd0
    };

    // black, white and the three greys carry no chroma
    localparam logic chroma_amp [0:15] = '{
        1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
        1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0
    };

    // one carrier cycle, 32 +/- 31
    localparam chroma_t sine_table [0:15] = '{
        6'd32, 6'd44, 6'd54, 6'd61, 6'd63, 6'd61, 6'd54, 6'd44,
        6'd32, 6'd20, 6'd10, 6'd3,  6'd1,  6'd3,  6'd10, 6'd20
    };

endpackage

// File: design/register_bank.sv
`timescale 1ns/10ps

module register_bank (
    input  logic                   clk_col16x_ntsc,
    input  logic                   rst_n,
    input  logic                   ce,           // low selects the chip
    input  logic                   rw,           // high = cpu read
    input  vic_bus_pkg::reg_addr_t adl_in,
    input  vic_bus_pkg::bus_data_t dbl_in,
    input  vic_video_pkg::raster_t raster,       // current line
    input  logic                   line_start,   // tick 0 of the line
    output vic_bus_pkg::bus_data_t dbl_out,
    output logic                   dbl_oe,
    output vic_bus_pkg::color_t    border_color,
    output vic_bus_pkg::color_t    bg_color,
    output logic                   irq           // active low
);
    import vic_bus_pkg::*;
    import vic_video_pkg::*;

    logic      wr_en;
    logic      rd_en;
    raster_t   compare;   // raster compare line
    logic      irq_en;
    logic      irq_flag;  // raster match seen
    bus_data_t rd_byte;

    assign wr_en = ~ce & ~rw;
    assign rd_en = ~ce & rw;

    // write decode, flag set and clear
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            border_color <= '0;
            bg_color     <= '0;
            compare      <= 9'h1ff; // no line reaches 511
            irq_en       <= 1'b0;
            irq_flag     <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                case (adl_in)
                    reg_raster:   compare[7:0] <= dbl_in;
                    reg_ctrl:     compare[8] <= dbl_in[ctrl_rst8_bit];
                    reg_irq_en:   irq_en <= dbl_in[irq_en_rst_bit];
                    reg_border:   border_color <= dbl_in[color_msb:0];
                    reg_bg:       bg_color <= dbl_in[color_msb:0];
                    reg_irq_flag:
                    begin
                        if (dbl_in[irq_raster_bit])
                            irq_flag <= 1'b0; // write one to ack
                    end
                    default: ;
                endcase
            end
            // a new match beats an ack in the same cycle
            if (line_start && raster == compare)
                irq_flag <= 1'b1;
        end
    end

    // read mux, everything not backed by a flop reads as 1
    always_comb
    begin
        rd_byte = read_fill;
        case (adl_in)
            reg_raster:   rd_byte = raster[7:0];
            reg_ctrl:     rd_byte[ctrl_rst8_bit] = raster[8];
            reg_irq_flag: rd_byte[irq_raster_bit] = irq_flag;
            reg_irq_en:   rd_byte[irq_en_rst_bit] = irq_en;
            reg_border:   rd_byte[color_msb:0] = border_color;
            reg_bg:       rd_byte[color_msb:0] = bg_color;
            default: ;
        endcase
    end

    // drive enable and irq pin
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dbl_oe <= 1'b0;
            irq    <= 1'b1;
        end
        else
        begin
            dbl_oe <= rd_en;                  // falls one edge after the read ends
            irq    <= ~(irq_flag & irq_en);
        end
    end

    // read data refreshed every cycle of the read, raster may move under it
    always_ff @(posedge clk_col16x_ntsc)
    begin
        if (rd_en)
            dbl_out <= rd_byte;
    end

endmodule

// File: design/raster_timing.sv
`timescale 1ns/10ps

module raster_timing (
    input  logic                   clk_col16x_ntsc,
    input  logic                   rst_n,
    output vic_video_pkg::raster_t raster,      // line 0..262
    output vic_video_pkg::hcount_t hcount,      // tick 0..259
    output logic                   hsync,       // active low, registered
    output logic                   vsync,       // active low, registered
    output logic                   in_display,  // inside the window, registered
    output logic                   line_start   // pulse at tick 0
);
    import vic_video_pkg::*;

    logic line_end;
    logic h_in_win;
    logic v_in_win;

    assign line_end   = (hcount == h_total - 9'd1);
    assign line_start = (hcount == '0);

    assign h_in_win = (hcount >= disp_h_start) && (hcount <= disp_h_end);
    assign v_in_win = (raster >= disp_v_start) && (raster <= disp_v_end);

    // tick and line counters
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hcount <= '0;
            raster <= '0;
        end
        else
        begin
            if (line_end)
            begin
                hcount <= '0;
                if (raster == v_total - 9'd1)
                    raster <= '0;   // new frame
                else
                    raster <= raster + 9'd1;
            end
            else
            begin
                hcount <= hcount + 9'd1;
            end
        end
    end

    // syncs and window trail the counters by one clock
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hsync      <= 1'b1;
            vsync      <= 1'b1;
            in_display <= 1'b0;
        end
        else
        begin
            hsync      <= (hcount >= hsync_ticks);
            vsync      <= (raster >= vsync_lines);
            in_display <= h_in_win & v_in_win;
        end
    end

endmodule

// File: design/luma_chroma_encoder.sv
`timescale 1ns/10ps

module luma_chroma_encoder (
    input  logic                       clk_col16x_ntsc,
    input  logic                       rst_n,
    input  logic                       hsync,        // active low
    input  logic                       vsync,        // active low
    input  logic                       in_display,
    input  vic_bus_pkg::color_t        border_color,
    input  vic_bus_pkg::color_t        bg_color,
    output vic_video_pkg::luma_level_t luma,
    output vic_video_pkg::chroma_t     chroma,
    output logic                       luma_sink     // high while in sync
);
    import vic_bus_pkg::*;
    import vic_video_pkg::*;

    phase_t      phase;      // carrier phase, one step per clock
    phase_t      sine_idx;
    color_t      pix_color;
    logic        in_sync;
    luma_level_t luma_nxt;
    chroma_t     chroma_nxt;

    // 16 clocks make one color carrier cycle
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
            phase <= '0;
        else
            phase <= phase + 4'd1;
    end

    assign in_sync   = ~hsync | ~vsync;
    assign pix_color = in_display ? bg_color : border_color;
    assign sine_idx  = phase + chroma_phase[pix_color];  // wraps mod 16

    always_comb
    begin
        if (in_sync)
        begin
            luma_nxt   = blank_level;
            chroma_nxt = chroma_mid;   // no burst in this cut
        end
        else
        begin
            luma_nxt = luma_table[pix_color];
            if (chroma_amp[pix_color])
                chroma_nxt = sine_table[sine_idx];
            else
                chroma_nxt = chroma_mid;   // greys sit on the midpoint
        end
    end

    // output stage
    always_ff @(posedge clk_col16x_ntsc or negedge rst_n)
    begin
        if (!rst_n)
        begin
            luma      <= blank_level;
            chroma    <= chroma_mid;
            luma_sink <= 1'b0;
        end
        else
        begin
            luma      <= luma_nxt;
            chroma    <= chroma_nxt;
            luma_sink <= in_sync;   // lets the board pull luma down to sync
        end
    end

endmodule

// File: design/vic_core.sv
`timescale 1ns/10ps

module vic_core (
    input  logic                       clk_col16x_ntsc,
    input  logic                       rst_n,
    input  logic                       ce,
    input  logic                       rw,
    input  vic_bus_pkg::reg_addr_t     adl_in,
    input  vic_bus_pkg::bus_data_t     dbl_in,
    output vic_bus_pkg::bus_data_t     dbl_out,
    output logic                       dbl_oe,     // single enable for the byte
    output logic                       irq,
    output logic                       hsync,
    output logic                       vsync,
    output vic_video_pkg::luma_level_t luma,
    output vic_video_pkg::chroma_t     chroma,
    output logic                       luma_sink
);
    import vic_bus_pkg::*;
    import vic_video_pkg::*;

    raster_t raster;
    logic    line_start;
    logic    in_display;
    color_t  border_color;
    color_t  bg_color;

    register_bank regs0 (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .ce              (ce),
        .rw              (rw),
        .adl_in          (adl_in),
        .dbl_in          (dbl_in),
        .raster          (raster),
        .line_start      (line_start),
        .dbl_out         (dbl_out),
        .dbl_oe          (dbl_oe),
        .border_color    (border_color),
        .bg_color        (bg_color),
        .irq             (irq)
    );

    // tick count stays inside the timing block for now
    raster_timing timing0 (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .raster          (raster),
        .hcount          (),
        .hsync           (hsync),
        .vsync           (vsync),
        .in_display      (in_display),
        .line_start      (line_start)
    );

    luma_chroma_encoder enc0 (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .hsync           (hsync),
        .vsync           (vsync),
        .in_display      (in_display),
        .border_color    (border_color),
        .bg_color        (bg_color),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

endmodule

// File: design/board_top.sv
`timescale 1ns/10ps

module board_top (
    input  logic                       clk_col16x_ntsc,  // 16x ntsc color carrier
    input  logic                       rst_n,
    input  logic                       ce,               // chip enable, low active
    input  logic                       rw,               // low = write
    input  vic_bus_pkg::reg_addr_t     adl_in,           // low address lines
    input  vic_bus_pkg::bus_data_t     dbl_in,           // data pins, in half
    output vic_bus_pkg::bus_data_t     dbl_out,          // data pins, out half
    output vic_bus_pkg::bus_data_t     dbl_oe,           // per-pin output enable
    output logic                       ls245_data_dir,   // transceiver dir, high = chip drives
    output logic                       irq,              // open drain on the board
    output logic                       hsync,
    output logic                       vsync,
    output vic_video_pkg::luma_level_t luma,
    output vic_video_pkg::chroma_t     chroma,
    output logic                       luma_sink
);
    logic core_oe;  // one enable for the whole data byte

    vic_core core0 (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .ce              (ce),
        .rw              (rw),
        .adl_in          (adl_in),
        .dbl_in          (dbl_in),
        .dbl_out         (dbl_out),
        .dbl_oe          (core_oe),
        .irq             (irq),
        .hsync           (hsync),
        .vsync           (vsync),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

    // io ring wants an enable per pad
    assign dbl_oe = {8{core_oe}};

    // point the ls245 toward the cpu only while we answer a read,
    // otherwise it faces the chip so writes come through
    assign ls245_data_dir = core_oe;

endmodule

// File: testbench/tb_board_top.sv
`timescale 1ns/10ps

module tb_board_top;
    import vic_bus_pkg::*;
    import vic_video_pkg::*;

    typedef enum int {op_write, op_read, op_wait_line, op_check_irq} op_t;

    localparam int max_steps   = 32;
    localparam int line_ticks  = int'(h_total);
    localparam int frame_lines = int'(v_total);

    logic        clk_col16x_ntsc = 1'b0;
    logic        rst_n;
    logic        ce;
    logic        rw;
    reg_addr_t   adl_in;
    bus_data_t   dbl_in;
    bus_data_t   dbl_out;
    bus_data_t   dbl_oe;
    logic        ls245_data_dir;
    logic        irq;
    logic        hsync;
    logic        vsync;
    luma_level_t luma;
    chroma_t     chroma;
    logic        luma_sink;

    op_t       step_op   [max_steps];   // stimulus table
    reg_addr_t step_addr [max_steps];
    int        step_data [max_steps];   // write byte or target line
    int        step_exp  [max_steps];   // read byte or irq level
    int        n_steps = 0;
    bit [31:0] lcg_state = 32'h12c3;
    int        err_cnt = 0;

    int     clk_cnt = 0;        // clocks since reset release
    int     stable_from = 4;    // video checked from this clock on
    color_t exp_border = '0;
    color_t exp_bg = '0;

    // position rebuilt from sync edges
    int   h_pos = 0;
    int   line_pos = 0;
    bit   pos_valid = 1'b0;
    logic hs_prev = 1'b1;
    logic vs_prev = 1'b1;
    bit   hs_fall;
    bit   vs_fall;
    int   h_now;
    int   l_now;
    int   hs_low = 0;           // clocks of the current pulse
    int   vs_low = 0;
    int   hs_since = 0;         // clocks since the last falling edge
    int   vs_since = 0;
    bit   hs_seen = 1'b0;
    bit   vs_seen = 1'b0;
    int   vs_periods = 0;       // whole frames measured

    board_top dut0 (
        .clk_col16x_ntsc (clk_col16x_ntsc),
        .rst_n           (rst_n),
        .ce              (ce),
        .rw              (rw),
        .adl_in          (adl_in),
        .dbl_in          (dbl_in),
        .dbl_out         (dbl_out),
        .dbl_oe          (dbl_oe),
        .ls245_data_dir  (ls245_data_dir),
        .irq             (irq),
        .hsync           (hsync),
        .vsync           (vsync),
        .luma            (luma),
        .chroma          (chroma),
        .luma_sink       (luma_sink)
    );

    always #4 clk_col16x_ntsc = ~clk_col16x_ntsc;   // 8 ns period

    always @(posedge clk_col16x_ntsc)
    begin
        if (rst_n)
            clk_cnt <= clk_cnt + 1;   // matches the dut carrier phase
    end

    function automatic bit [31:0] lcg_next(input bit [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_val(input string name, input int got, input int expected);
        if (got != expected)
        begin
            $display("error: %s got %h expected %h", name, got, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // what the pins show now was formed from the counters two clocks back
    task automatic check_video(input int h_cur, input int l_cur);
        int         h2;
        int         l2;
        bit         in_sync;
        bit         in_win;
        color_t     pix;
        logic [3:0] ph;
        logic [3:0] sidx;
        int         e_luma;
        int         e_chroma;
        if (h_cur >= 2)
        begin
            h2 = h_cur - 2;
            l2 = l_cur;
        end
        else
        begin
            h2 = h_cur + line_ticks - 2;   // previous line
            l2 = (l_cur == 0) ? frame_lines - 1 : l_cur - 1;
        end
        in_sync = (h2 < int'(hsync_ticks)) || (l2 < int'(vsync_lines));
        in_win  = (h2 >= int'(disp_h_start)) && (h2 <= int'(disp_h_end))
               && (l2 >= int'(disp_v_start)) && (l2 <= int'(disp_v_end));
        pix  = in_win ? exp_bg : exp_border;
        ph   = 4'(clk_cnt - 1);   // phase one clock back
        sidx = ph + chroma_phase[pix];
        if (in_sync)
        begin
            e_luma   = int'(blank_level);
            e_chroma = 32;
        end
        else
        begin
            e_luma   = int'(luma_table[pix]);
            e_chroma = chroma_amp[pix] ? int'(sine_table[sidx]) : 32;   // greys stay mid
        end
        check_val("luma", int'(luma), e_luma);
        check_val("chroma", int'(chroma), e_chroma);
        check_val("luma_sink", int'(luma_sink), int'(in_sync));
    endtask

    // sync widths, periods and video sampled on the falling edge
    always @(negedge clk_col16x_ntsc)
    begin
        if (rst_n)
        begin
            hs_fall = hs_prev & ~hsync;
            vs_fall = vs_prev & ~vsync;
            hs_prev = hsync;
            vs_prev = vsync;
            if (!hsync)
                hs_low = hs_low + 1;
            else if (hs_low != 0)
            begin
                check_val("hsync_low_clocks", hs_low, int'(hsync_ticks));
                hs_low = 0;
            end
            if (!vsync)
                vs_low = vs_low + 1;
            else if (vs_low != 0)
            begin
                check_val("vsync_low_clocks", vs_low, int'(vsync_lines) * line_ticks);
                vs_low = 0;
            end
            if (hs_fall)
            begin
                if (hs_seen)
                    check_val("hsync_period", hs_since, line_ticks);
                hs_seen  = 1'b1;
                hs_since = 1;
            end
            else
                hs_since = hs_since + 1;
            if (vs_fall)
            begin
                if (vs_seen)
                begin
                    check_val("vsync_period", vs_since, frame_lines * line_ticks);
                    vs_periods <= vs_periods + 1;
                end
                vs_seen  = 1'b1;
                vs_since = 1;
            end
            else
                vs_since = vs_since + 1;
            // hsync falls one clock after tick 0, so the counter already reads 1
            if (hs_fall)
                h_now = 1;
            else if (h_pos == line_ticks - 1)
                h_now = 0;
            else
                h_now = h_pos + 1;
            if (vs_fall)
                l_now = 0;
            else if (h_now == 0)
                l_now = (line_pos + 1) % frame_lines;
            else
                l_now = line_pos;
            h_pos    <= h_now;
            line_pos <= l_now;
            if (vs_fall)
                pos_valid <= 1'b1;
            if (pos_valid && clk_cnt >= stable_from)
                check_video(h_now, l_now);
        end
    end

    task automatic add_step(input op_t op, input reg_addr_t addr, input int data,
                            input int expected);
        step_op[n_steps]   = op;
        step_addr[n_steps] = addr;
        step_data[n_steps] = data;
        step_exp[n_steps]  = expected;
        n_steps = n_steps + 1;
    endtask

    task automatic build_table();
        int c_border;
        int c_bg;
        int c_bg2;
        lcg_state = lcg_next(lcg_state);
        c_border  = int'(lcg_state[27:24]);
        lcg_state = lcg_next(lcg_state);
        c_bg      = int'(lcg_state[27:24]);
        lcg_state = lcg_next(lcg_state);
        c_bg2     = int'(lcg_state[27:24]);
        add_step(op_write, reg_border, c_border, 0);
        add_step(op_write, reg_bg, c_bg, 0);
        add_step(op_read, reg_border, 0, 'hf0 | c_border);   // upper nibble floats high
        add_step(op_read, reg_bg, 0, 'hf0 | c_bg);
        add_step(op_read, 6'h3f, 0, 'hff);                     // unmapped
        add_step(op_read, 6'h00, 0, 'hff);
        add_step(op_write, reg_raster, 60, 0);                 // compare line 60
        add_step(op_write, reg_ctrl, 'h00, 0);
        add_step(op_write, reg_irq_en, 'h01, 0);
        add_step(op_read, reg_irq_en, 0, 'hff);
        add_step(op_check_irq, '0, 0, 1);
        add_step(op_wait_line, '0, 60, 0);
        add_step(op_check_irq, '0, 0, 1);                      // irq flop still one clock behind
        add_step(op_check_irq, '0, 0, 0);
        add_step(op_read, reg_raster, 0, 'h3c);                // still early in line 60
        add_step(op_write, reg_irq_flag, 'h01, 0);             // ack
        add_step(op_check_irq, '0, 0, 1);
        add_step(op_read, reg_irq_flag, 0, 'hfe);
        add_step(op_write, reg_border, 'h0c, 0);               // grey has no chroma
        add_step(op_write, reg_bg, c_bg2, 0);
        add_step(op_wait_line, '0, 256, 0);
        add_step(op_read, reg_ctrl, 0, 'hff);                  // raster bit 8 set
        add_step(op_read, reg_raster, 0, 'h00);
        add_step(op_write, reg_irq_en, 'h00, 0);
        add_step(op_wait_line, '0, 5, 0);                      // into the next frame
    endtask

    task automatic drive_write(input reg_addr_t addr, input int data);
        @(posedge clk_col16x_ntsc);
        #1;
        ce     = 1'b0;
        rw     = 1'b0;
        adl_in = addr;
        dbl_in = data[7:0];
        @(posedge clk_col16x_ntsc);   // register takes the byte here
        #1;
        ce = 1'b1;
        rw = 1'b1;
        if (addr == reg_border)
            exp_border = data[3:0];
        if (addr == reg_bg)
            exp_bg = data[3:0];
        stable_from = clk_cnt + 1;   // new color reaches the pins on the next clock
    endtask

    task automatic drive_read(input reg_addr_t addr, input int expected);
        @(posedge clk_col16x_ntsc);
        #1;
        ce     = 1'b0;
        rw     = 1'b1;
        adl_in = addr;
        @(posedge clk_col16x_ntsc);
        @(negedge clk_col16x_ntsc);
        check_val("dbl_out", int'(dbl_out), expected);
        check_val("dbl_oe", int'(dbl_oe), 'hff);
        check_val("ls245_data_dir", int'(ls245_data_dir), 1);
        @(posedge clk_col16x_ntsc);
        #1;
        ce = 1'b1;
        @(posedge clk_col16x_ntsc);   // enable drops one edge after the read
        @(negedge clk_col16x_ntsc);
        check_val("dbl_oe", int'(dbl_oe), 0);
        check_val("ls245_data_dir", int'(ls245_data_dir), 0);
    endtask

    task automatic run_step(input int i);
        int waited;
        case (step_op[i])
            op_write: drive_write(step_addr[i], step_data[i]);
            op_read:  drive_read(step_addr[i], step_exp[i]);
            op_wait_line:
            begin
                while (!(pos_valid && line_pos == step_data[i]))
                    @(negedge clk_col16x_ntsc);
            end
            op_check_irq:
            begin
                waited = 0;
                while (int'(irq) != step_exp[i] && waited < 8)   // flag then irq flop
                begin
                    @(negedge clk_col16x_ntsc);
                    waited = waited + 1;
                end
                check_val("irq", int'(irq), step_exp[i]);
            end
            default: ;
        endcase
    endtask

    initial
    begin
        longint limit_ns;
        wait (n_steps > 0);
        limit_ns = longint'(n_steps + 3) * frame_lines * line_ticks * 8;
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        rst_n  = 1'b0;
        ce     = 1'b1;
        rw     = 1'b1;
        adl_in = '0;
        dbl_in = '0;
        build_table();
        @(negedge clk_col16x_ntsc);   // inside reset after the first edge
        check_val("irq", int'(irq), 1);
        check_val("dbl_oe", int'(dbl_oe), 0);
        check_val("ls245_data_dir", int'(ls245_data_dir), 0);
        check_val("hsync", int'(hsync), 1);
        check_val("vsync", int'(vsync), 1);
        check_val("luma", int'(luma), int'(blank_level));
        check_val("chroma", int'(chroma), 32);
        repeat (2) @(posedge clk_col16x_ntsc);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++)
            run_step(i);
        if (vs_periods == 0)
        begin
            $display("no complete frame was measured on vsync");
            err_cnt = err_cnt + 1;
        end
        if (err_cnt == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            $display("FAIL: see errors above");
            $fatal(1, "run ended with failures");
        end
    end

endmodule

// File: files.f
design/vic_bus_pkg.sv
design/vic_video_pkg.sv
design/register_bank.sv
design/raster_timing.sv
design/luma_chroma_encoder.sv
design/vic_core.sv
design/board_top.sv
testbench/tb_board_top.sv

// File: run_sim.sh
#!/bin/sh
# build tb_board_top with verilator, run it, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module tb_board_top -o tb_board_top_sim \
    && ./obj_dir/tb_board_top_sim 2>&1 | tee sim.log
grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
